// ==== verilog/rvfi_mem_check_pkg.sv ====
// RVFI memory checker definitions

package rvfi_mem_check_pkg;

  ////////////////////
  // Enumerations
  ////////////////////

  // Kind of memory operation carried by one retired instruction
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  // Exception causes that stop a load or store from reaching memory
  typedef enum logic [5:0] {
    EXC_LD_MISALIGN = 6'd4,
    EXC_LD_FAULT    = 6'd5,
    EXC_ST_MISALIGN = 6'd6,
    EXC_ST_FAULT    = 6'd7
  } exc_cause_e;

  ////////////////////
  // Bus payloads
  ////////////////////

  // One granted OBI data request, 71 bits
  typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic [2:0]  prot;
  } obi_req_t;

  // One OBI data response, 33 bits
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } obi_resp_t;

  ////////////////////
  // Retirement side
  ////////////////////

  // One queued retirement report with its memory operation
  // The mask is already aligned to the address low bits, as on RVFI
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] rdata;
    logic [31:0] wdata;
    logic [3:0]  mask;
    mem_op_e     op;
    logic [2:0]  prot;
    logic        blocked;
    logic        split;
  } retire_rec_t;

  // One mismatch flag per compared field
  typedef struct packed {
    logic addr;
    logic mask;
    logic data;
    logic prot;
  } check_err_t;

  // Capture depth must be a power of two, the pointers wrap naturally
  localparam int unsigned DEF_FIFO_DEPTH   = 8;
  localparam int unsigned DEF_RETIRE_DEPTH = 4;

endpackage

// ==== verilog/mem_check_ifs.sv ====
// Checker internal interfaces

`timescale 1ns/1ps

// Head of the OBI capture FIFO as seen by the comparator
interface fifo_head_if #(
  parameter int unsigned FIFO_DEPTH = 8
);

  // Oldest captured transfer and the one behind it
  rvfi_mem_check_pkg::obi_req_t  head_req;
  rvfi_mem_check_pkg::obi_resp_t head_resp;
  rvfi_mem_check_pkg::obi_req_t  next_req;
  rvfi_mem_check_pkg::obi_resp_t next_resp;

  // Number of transfers with both request and response captured
  logic [$clog2(FIFO_DEPTH):0] avail;

  // Pop consumes one transfer, two when pop_two is high as well
  logic pop;
  logic pop_two;

  modport fifo (
    output head_req, head_resp, next_req, next_resp, avail,
    input  pop, pop_two
  );

  modport cmp (
    input  head_req, head_resp, next_req, next_resp, avail,
    output pop, pop_two
  );

endinterface

// Head of the retirement queue as seen by the comparator
interface retire_head_if;

  rvfi_mem_check_pkg::retire_rec_t rec;
  logic                            rec_valid;
  logic                            pop;

  modport queue (output rec, rec_valid, input pop);
  modport cmp (input rec, rec_valid, output pop);

endinterface

// ==== verilog/obi_capture_fifo.sv ====
// OBI transfer capture FIFO

`timescale 1ns/1ps

module obi_capture_fifo #(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          obi_req_i,
  input  logic                          obi_gnt_i,
  input  rvfi_mem_check_pkg::obi_req_t  obi_req_data_i,
  input  logic                          obi_rvalid_i,
  input  rvfi_mem_check_pkg::obi_resp_t obi_resp_data_i,
  fifo_head_if.fifo                     head,
  output logic                          overflow_o
);

  // Index width, plus one wrap bit on every pointer
  localparam int unsigned AW = $clog2(FIFO_DEPTH);
  localparam int unsigned PW = AW + 1;

  rvfi_mem_check_pkg::obi_req_t  req_mem  [FIFO_DEPTH];
  rvfi_mem_check_pkg::obi_resp_t resp_mem [FIFO_DEPTH];

  logic [PW-1:0] wr_req_ptr_q;
  logic [PW-1:0] wr_resp_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [PW-1:0] req_cnt;
  logic [PW-1:0] resp_cnt;
  logic [AW-1:0] rd_idx_next;
  logic [1:0]    rd_step;
  logic          req_push;
  logic          resp_push;
  logic          req_full;
  logic          resp_full;
  logic          overflow_q;

  ////////////////////
  // Occupancy
  ////////////////////

  // Responses lag requests, so the response count is the number of
  // complete transfers
  assign req_cnt  = wr_req_ptr_q - rd_ptr_q;
  assign resp_cnt = wr_resp_ptr_q - rd_ptr_q;

  assign req_full  = (req_cnt == PW'(FIFO_DEPTH));
  assign resp_full = (resp_cnt == PW'(FIFO_DEPTH));

  // A granted request is one transfer, rvalid marks its response
  assign req_push  = obi_req_i && obi_gnt_i;
  assign resp_push = obi_rvalid_i;

  // Comparator consumes one transfer, or both halves of a split access
  assign rd_step = head.pop ? (head.pop_two ? 2'd2 : 2'd1) : 2'd0;

  ////////////////////
  // Pointers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_req_ptr_q  <= '0;
      wr_resp_ptr_q <= '0;
      rd_ptr_q      <= '0;
      overflow_q    <= 1'b0;
    end else begin
      if (req_push && !req_full) begin
        wr_req_ptr_q <= wr_req_ptr_q + 1'b1;
      end
      if (resp_push && !resp_full) begin
        wr_resp_ptr_q <= wr_resp_ptr_q + 1'b1;
      end
      rd_ptr_q <= rd_ptr_q + PW'(rd_step);
      // Once a transfer is lost the pairing is broken, so keep the flag
      if ((req_push && req_full) || (resp_push && resp_full)) begin
        overflow_q <= 1'b1;
      end
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (req_push && !req_full) begin
      req_mem[wr_req_ptr_q[AW-1:0]] <= obi_req_data_i;
    end
    if (resp_push && !resp_full) begin
      resp_mem[wr_resp_ptr_q[AW-1:0]] <= obi_resp_data_i;
    end
  end

  ////////////////////
  // Head outputs
  ////////////////////

  assign rd_idx_next = rd_ptr_q[AW-1:0] + 1'b1;

  assign head.head_req  = req_mem[rd_ptr_q[AW-1:0]];
  assign head.head_resp = resp_mem[rd_ptr_q[AW-1:0]];
  assign head.next_req  = req_mem[rd_idx_next];
  assign head.next_resp = resp_mem[rd_idx_next];
  assign head.avail     = resp_cnt;

  assign overflow_o = overflow_q;

  // The comparator must never consume transfers that are not complete
  a_pop_within_avail: assert property (@(posedge clk_i) disable iff (!rst_ni)
    head.pop |-> (head.avail >= (head.pop_two ? 2 : 1)));

  // Every response belongs to a request granted in an earlier cycle
  a_resp_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (obi_rvalid_i && !overflow_q) |-> (wr_resp_ptr_q != wr_req_ptr_q));

endmodule

// ==== verilog/retire_queue.sv ====
// Retirement report queue

`timescale 1ns/1ps

module retire_queue #(
  parameter int unsigned RETIRE_DEPTH = 4
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        rvfi_valid_i,
  input  logic [31:0] rvfi_addr_i,
  input  logic [31:0] rvfi_rdata_i,
  input  logic [31:0] rvfi_wdata_i,
  input  logic [3:0]  rvfi_rmask_i,
  input  logic [3:0]  rvfi_wmask_i,
  input  logic [2:0]  rvfi_prot_i,
  input  logic        rvfi_trap_i,
  input  logic [5:0]  rvfi_exc_cause_i,
  retire_head_if.queue head,
  output logic        overflow_o
);

  localparam int unsigned IW = (RETIRE_DEPTH > 1) ? $clog2(RETIRE_DEPTH) : 1;
  localparam int unsigned CW = $clog2(RETIRE_DEPTH + 1);

  rvfi_mem_check_pkg::retire_rec_t rec_mem [RETIRE_DEPTH];
  rvfi_mem_check_pkg::retire_rec_t new_rec;

  logic [IW-1:0] wr_ptr_q;
  logic [IW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic [3:0]    mask;
  logic [2:0]    span;
  logic          cause_blocks;
  logic          push;
  logic          full;
  logic          overflow_q;

  ////////////////////
  // Record build
  ////////////////////

  // Only one of the masks is set, so the union is the access mask
  assign mask = rvfi_rmask_i | rvfi_wmask_i;

  // Low address bits plus bytes touched, past four means two bus transfers
  assign span = {1'b0, rvfi_addr_i[1:0]} + 3'($countones(mask));

  // Misaligned and access-fault traps never reach memory
  always_comb begin
    case (rvfi_exc_cause_i)
      rvfi_mem_check_pkg::EXC_LD_MISALIGN,
      rvfi_mem_check_pkg::EXC_LD_FAULT,
      rvfi_mem_check_pkg::EXC_ST_MISALIGN,
      rvfi_mem_check_pkg::EXC_ST_FAULT: cause_blocks = 1'b1;
      default:                          cause_blocks = 1'b0;
    endcase
  end

  always_comb begin
    new_rec.addr    = rvfi_addr_i;
    new_rec.rdata   = rvfi_rdata_i;
    new_rec.wdata   = rvfi_wdata_i;
    new_rec.mask    = mask;
    new_rec.op      = (|rvfi_wmask_i) ? rvfi_mem_check_pkg::MEM_WRITE
                                      : rvfi_mem_check_pkg::MEM_READ;
    new_rec.prot    = rvfi_prot_i;
    new_rec.blocked = rvfi_trap_i && cause_blocks;
    new_rec.split   = (span > 3'd4);
  end

  ////////////////////
  // Queue control
  ////////////////////

  // Instructions without a memory operation are not checked
  assign push = rvfi_valid_i && (|mask);
  assign full = (count_q == CW'(RETIRE_DEPTH));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (push && !full) begin
        wr_ptr_q <= (wr_ptr_q == IW'(RETIRE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (head.pop) begin
        rd_ptr_q <= (rd_ptr_q == IW'(RETIRE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Occupancy moves only when exactly one side acts
      if ((push && !full) && !head.pop) begin
        count_q <= count_q + 1'b1;
      end else if (!(push && !full) && head.pop) begin
        count_q <= count_q - 1'b1;
      end
      if (push && full) begin
        overflow_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push && !full) begin
      rec_mem[wr_ptr_q] <= new_rec;
    end
  end

  assign head.rec       = rec_mem[rd_ptr_q];
  assign head.rec_valid = (count_q != '0);
  assign overflow_o     = overflow_q;

  // One memory operation per instruction, either a load or a store
  a_single_mask: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid_i |-> !((|rvfi_rmask_i) && (|rvfi_wmask_i)));

endmodule

// ==== verilog/mem_op_compare.sv ====
// Memory report comparator

`timescale 1ns/1ps

module mem_op_compare (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  fifo_head_if.cmp                       fifo,
  retire_head_if.cmp                     retire,
  output logic                           check_valid_o,
  output rvfi_mem_check_pkg::check_err_t check_err_o
);

  // Expand byte enables into a bit mask
  function automatic logic [31:0] byte_bits(input logic [3:0] be);
    logic [31:0] bits;
    for (int i = 0; i < 4; i++) begin
      bits[8*i +: 8] = {8{be[i]}};
    end
    return bits;
  endfunction

  logic [1:0]  lo;
  logic [2:0]  hi_shift;
  logic [4:0]  lo_bits;
  logic [5:0]  hi_bits;
  logic        is_write;
  logic [31:0] first_data;
  logic [31:0] second_data;
  logic [31:0] split_data;
  logic [3:0]  split_mask;
  logic [3:0]  exp_mask;
  logic [31:0] exp_data;
  logic [31:0] rep_data;
  logic [31:0] rep_bits;
  logic        go;
  logic        check_valid_q;

  rvfi_mem_check_pkg::check_err_t err_d;
  rvfi_mem_check_pkg::check_err_t err_q;

  ////////////////////
  // Pop decision
  ////////////////////

  // A split record needs both transfers complete before it can be checked
  assign go = retire.rec_valid &&
              (retire.rec.split ? (fifo.avail >= 2) : (fifo.avail >= 1));

  assign retire.pop   = go;
  assign fifo.pop     = go;
  assign fifo.pop_two = go && retire.rec.split;

  ////////////////////
  // Expected report
  ////////////////////

  // Byte offset of the access within the first bus word
  assign lo       = fifo.head_req.addr[1:0];
  assign hi_shift = 3'd4 - {1'b0, lo};
  assign lo_bits  = {lo, 3'b000};
  assign hi_bits  = {hi_shift, 3'b000};

  assign is_write = (retire.rec.op == rvfi_mem_check_pkg::MEM_WRITE);

  // Stores carry data in the request, loads in the response
  assign first_data  = is_write ? fifo.head_req.wdata : fifo.head_resp.rdata;
  assign second_data = is_write ? fifo.next_req.wdata : fifo.next_resp.rdata;

  // First half supplies the low bytes, second half the bytes above it
  assign split_mask = (fifo.head_req.be >> lo) | (fifo.next_req.be << hi_shift);
  assign split_data = ((first_data & byte_bits(fifo.head_req.be)) >> lo_bits) |
                      ((second_data & byte_bits(fifo.next_req.be)) << hi_bits);

  always_comb begin
    if (retire.rec.split) begin
      exp_mask = split_mask;
      exp_data = split_data;
    end else begin
      exp_mask = fifo.head_req.be >> lo;
      exp_data = first_data >> lo_bits;
    end
  end

  ////////////////////
  // Field checks
  ////////////////////

  assign rep_data = is_write ? retire.rec.wdata : retire.rec.rdata;
  assign rep_bits = byte_bits(retire.rec.mask);

  // Address and prot are equal on both halves, so the first one is enough
  always_comb begin
    err_d.addr = (retire.rec.addr != fifo.head_req.addr);
    err_d.mask = (retire.rec.mask != exp_mask);
    // Only bytes the core claims to have accessed are meaningful
    // and a blocked access has no bus data to match
    err_d.data = !retire.rec.blocked && (((exp_data ^ rep_data) & rep_bits) != '0);
    err_d.prot = (retire.rec.prot != fifo.head_req.prot);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      check_valid_q <= 1'b0;
    end else begin
      check_valid_q <= go;
    end
  end

  // Result flags are held until the next check
  always_ff @(posedge clk_i) begin
    if (go) begin
      err_q <= err_d;
    end
  end

  assign check_valid_o = check_valid_q;
  assign check_err_o   = err_q;

  // The two halves of a split access sit in one word and the word after it
  a_split_pairing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fifo.pop_two |-> (fifo.next_req.addr == {fifo.head_req.addr[31:2], 2'b00} + 32'd4));

endmodule

// ==== verilog/rvfi_mem_checker.sv ====
// RVFI memory report checker

`timescale 1ns/1ps

module rvfi_mem_checker #(
  parameter int unsigned FIFO_DEPTH   = rvfi_mem_check_pkg::DEF_FIFO_DEPTH,
  parameter int unsigned RETIRE_DEPTH = rvfi_mem_check_pkg::DEF_RETIRE_DEPTH
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Observed OBI data bus
  input  logic                           obi_req_i,
  input  logic                           obi_gnt_i,
  input  logic [31:0]                    obi_addr_i,
  input  logic [3:0]                     obi_be_i,
  input  logic [31:0]                    obi_wdata_i,
  input  logic [2:0]                     obi_prot_i,
  input  logic                           obi_rvalid_i,
  input  logic [31:0]                    obi_rdata_i,
  input  logic                           obi_err_i,
  // Retirement trace
  input  logic                           rvfi_valid_i,
  input  logic [31:0]                    rvfi_mem_addr_i,
  input  logic [3:0]                     rvfi_mem_rmask_i,
  input  logic [3:0]                     rvfi_mem_wmask_i,
  input  logic [31:0]                    rvfi_mem_rdata_i,
  input  logic [31:0]                    rvfi_mem_wdata_i,
  input  logic [2:0]                     rvfi_mem_prot_i,
  input  logic                           rvfi_trap_i,
  input  logic [5:0]                     rvfi_exc_cause_i,
  // Results
  output logic                           check_valid_o,
  output rvfi_mem_check_pkg::check_err_t check_err_o,
  output logic                           fifo_overflow_o,
  output logic                           retire_overflow_o
);

  rvfi_mem_check_pkg::obi_req_t  obi_req_data;
  rvfi_mem_check_pkg::obi_resp_t obi_resp_data;

  // Bus payload packed for storage
  assign obi_req_data  = '{addr: obi_addr_i, be: obi_be_i, wdata: obi_wdata_i, prot: obi_prot_i};
  assign obi_resp_data = '{rdata: obi_rdata_i, err: obi_err_i};

  fifo_head_if #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_head ();
  retire_head_if                          retire_head ();

  obi_capture_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) obi_capture_fifo_i (
    .clk_i, .rst_ni, .obi_req_i, .obi_gnt_i,
    .obi_req_data_i  (obi_req_data),
    .obi_rvalid_i,
    .obi_resp_data_i (obi_resp_data),
    .head            (fifo_head),
    .overflow_o      (fifo_overflow_o)
  );

  retire_queue #(.RETIRE_DEPTH(RETIRE_DEPTH)) retire_queue_i (
    .clk_i, .rst_ni, .rvfi_valid_i,
    .rvfi_addr_i      (rvfi_mem_addr_i),
    .rvfi_rdata_i     (rvfi_mem_rdata_i),
    .rvfi_wdata_i     (rvfi_mem_wdata_i),
    .rvfi_rmask_i     (rvfi_mem_rmask_i),
    .rvfi_wmask_i     (rvfi_mem_wmask_i),
    .rvfi_prot_i      (rvfi_mem_prot_i),
    .rvfi_trap_i, .rvfi_exc_cause_i,
    .head             (retire_head),
    .overflow_o       (retire_overflow_o)
  );

  mem_op_compare mem_op_compare_i (
    .clk_i, .rst_ni,
    .fifo   (fifo_head),
    .retire (retire_head),
    .check_valid_o, .check_err_o
  );

endmodule

// ==== dv/tb_rvfi_mem_checker.sv ====
// RVFI memory checker testbench

`timescale 1ns/1ps

module tb_rvfi_mem_checker;

  // Kinds of instruction stream, one per test
  localparam int ALIGNED = 0;
  localparam int SPLIT   = 1;
  localparam int CORRUPT = 2;
  localparam int BLOCKED = 3;
  localparam int NOMEM   = 4;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        obi_req;
  logic        obi_gnt;
  logic [31:0] obi_addr;
  logic [3:0]  obi_be;
  logic [31:0] obi_wdata;
  logic [2:0]  obi_prot;
  logic        obi_rvalid;
  logic [31:0] obi_rdata;
  logic        obi_err;
  logic        rvfi_valid;
  logic [31:0] rvfi_addr;
  logic [3:0]  rvfi_rmask;
  logic [3:0]  rvfi_wmask;
  logic [31:0] rvfi_rdata;
  logic [31:0] rvfi_wdata;
  logic [2:0]  rvfi_prot;
  logic        rvfi_trap;
  logic [5:0]  rvfi_exc_cause;
  logic        check_valid;
  logic        fifo_overflow;
  logic        retire_overflow;

  rvfi_mem_check_pkg::check_err_t check_err;
  // Expected results, in retirement order
  rvfi_mem_check_pkg::check_err_t exp_q [$];

  integer seed;
  int     err_cnt;
  int     check_cnt;
  int     n_expected;
  int     n_results;

  always #10 clk_i = ~clk_i;

  rvfi_mem_checker #(
    .FIFO_DEPTH   (rvfi_mem_check_pkg::DEF_FIFO_DEPTH),
    .RETIRE_DEPTH (rvfi_mem_check_pkg::DEF_RETIRE_DEPTH)
  ) rvfi_mem_checker_i (
    .clk_i, .rst_ni,
    .obi_req_i         (obi_req),
    .obi_gnt_i         (obi_gnt),
    .obi_addr_i        (obi_addr),
    .obi_be_i          (obi_be),
    .obi_wdata_i       (obi_wdata),
    .obi_prot_i        (obi_prot),
    .obi_rvalid_i      (obi_rvalid),
    .obi_rdata_i       (obi_rdata),
    .obi_err_i         (obi_err),
    .rvfi_valid_i      (rvfi_valid),
    .rvfi_mem_addr_i   (rvfi_addr),
    .rvfi_mem_rmask_i  (rvfi_rmask),
    .rvfi_mem_wmask_i  (rvfi_wmask),
    .rvfi_mem_rdata_i  (rvfi_rdata),
    .rvfi_mem_wdata_i  (rvfi_wdata),
    .rvfi_mem_prot_i   (rvfi_prot),
    .rvfi_trap_i       (rvfi_trap),
    .rvfi_exc_cause_i  (rvfi_exc_cause),
    .check_valid_o     (check_valid),
    .check_err_o       (check_err),
    .fifo_overflow_o   (fifo_overflow),
    .retire_overflow_o (retire_overflow)
  );

  ////////////////////
  // Checks
  ////////////////////

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic compare_err(input rvfi_mem_check_pkg::check_err_t got,
                             input rvfi_mem_check_pkg::check_err_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t: check_err_o is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // Every result is matched against the oldest expected entry
  always @(posedge clk_i) begin
    if (rst_ni && check_valid) begin
      n_results++;
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("A result came out at %0t with no memory retirement behind it", $time);
      end else begin
        compare_err(check_err, exp_q.pop_front());
      end
    end
  end

  ////////////////////
  // Bus and trace drivers
  ////////////////////

  // One bus transfer, request held until granted, then its response
  task automatic drive_transfer(input logic [31:0] addr, input logic [3:0] be,
                                input logic [31:0] wdata, input logic [31:0] rdata,
                                input logic [2:0] prot, input int gnt_wait,
                                input int rsp_wait);
    @(posedge clk_i);
    obi_req   <= 1'b1;
    obi_gnt   <= (gnt_wait == 0);
    obi_addr  <= addr;
    obi_be    <= be;
    obi_wdata <= wdata;
    obi_prot  <= prot;
    for (int i = 0; i < gnt_wait; i++) begin
      @(posedge clk_i);
      obi_gnt <= (i == gnt_wait - 1);
    end
    @(posedge clk_i);
    obi_req <= 1'b0;
    obi_gnt <= 1'b0;
    repeat (rsp_wait - 1) @(posedge clk_i);
    obi_rvalid <= 1'b1;
    obi_rdata  <= rdata;
    @(posedge clk_i);
    obi_rvalid <= 1'b0;
  endtask

  task automatic drive_retire(input int wait_cycles, input logic [31:0] addr,
                              input logic [3:0] rmask, input logic [3:0] wmask,
                              input logic [31:0] rdata, input logic [31:0] wdata,
                              input logic [2:0] prot, input logic trap,
                              input logic [5:0] cause);
    repeat (wait_cycles) @(posedge clk_i);
    @(posedge clk_i);
    rvfi_valid     <= 1'b1;
    rvfi_addr      <= addr;
    rvfi_rmask     <= rmask;
    rvfi_wmask     <= wmask;
    rvfi_rdata     <= rdata;
    rvfi_wdata     <= wdata;
    rvfi_prot      <= prot;
    rvfi_trap      <= trap;
    rvfi_exc_cause <= cause;
    @(posedge clk_i);
    rvfi_valid <= 1'b0;
    rvfi_trap  <= 1'b0;
  endtask

  ////////////////////
  // Instruction model
  ////////////////////

  task automatic run_instr(input int kind);
    int          size;
    int          lo;
    int          fault;
    int          ret_wait;
    int          gnt0;
    int          rsp0;
    int          gnt1;
    int          rsp1;
    logic        write;
    logic        split;
    logic        trap;
    logic [5:0]  cause;
    logic [7:0]  be_wide;
    logic [63:0] lane;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] size_bits;
    logic [31:0] rd0;
    logic [31:0] rd1;
    logic [31:0] rep_addr;
    logic [31:0] rep_rdata;
    logic [31:0] rep_wdata;
    logic [3:0]  rep_mask;
    logic [2:0]  prot;
    logic [2:0]  rep_prot;
    rvfi_mem_check_pkg::check_err_t exp;

    ret_wait = rand_below(9);
    // A retirement without a memory operation produces no result
    if (kind == NOMEM && rand_below(2) == 0) begin
      drive_retire(ret_wait, $random(seed), 4'h0, 4'h0, $random(seed), $random(seed),
                   3'h0, 1'b0, 6'h0);
      return;
    end
    case (kind)
      ALIGNED, NOMEM: begin
        size = 1 << rand_below(3);
        lo   = rand_below(4) & (4 - size);
      end
      SPLIT: begin
        size = (rand_below(2) == 0) ? 2 : 4;
        lo   = (size == 2) ? 3 : 1 + rand_below(3);
      end
      default: begin
        size = 1 << rand_below(3);
        lo   = rand_below(4);
      end
    endcase
    // Bytes past the end of the word go to the next word
    split     = (lo + size > 4);
    write     = (kind != BLOCKED) && (rand_below(2) == 1);
    addr      = $random(seed);
    addr[1:0] = 2'(lo);
    prot      = 3'(rand_below(8));
    size_bits = 32'hFFFF_FFFF >> (8 * (4 - size));
    data      = $random(seed) & size_bits;
    rd0       = $random(seed);
    rd1       = $random(seed);
    be_wide   = 8'((1 << size) - 1) << lo;
    lane      = {32'h0, data} << (8 * lo);

    // Honest report, loads hold the bytes read from the bus words
    rep_addr  = addr;
    rep_mask  = 4'((1 << size) - 1);
    rep_prot  = prot;
    rep_wdata = write ? data : $random(seed);
    if (write) begin
      rep_rdata = $random(seed);
    end else if (split) begin
      rep_rdata = 32'({rd1, rd0} >> (8 * lo)) & size_bits;
    end else begin
      rep_rdata = rd0 >> (8 * lo);
    end
    trap  = 1'b0;
    cause = 6'h0;
    exp   = '0;

    // Mask faults keep the byte count so the split class is unchanged
    fault = (kind == CORRUPT) ? rand_below(5) : 0;
    if (fault == 2 && size == 4 && lo != 0) begin
      fault = 4;
    end
    case (fault)
      1: begin
        rep_addr = addr ^ (32'd1 << (2 + rand_below(30)));
        exp.addr = 1'b1;
      end
      2: begin
        rep_mask = (size == 4) ? 4'b0111 : {rep_mask[2:0], rep_mask[3]};
        exp.mask = 1'b1;
      end
      3: begin
        if (write) begin
          rep_wdata = rep_wdata ^ 32'(1 + rand_below(255));
        end else begin
          rep_rdata = rep_rdata ^ 32'(1 + rand_below(255));
        end
        exp.data = 1'b1;
      end
      4: begin
        rep_prot = prot ^ 3'(1 + rand_below(7));
        exp.prot = 1'b1;
      end
      default: ;
    endcase

    // A blocked load hides bad read data but not a bad address
    if (kind == BLOCKED) begin
      trap      = 1'b1;
      cause     = 6'(4 + rand_below(4));
      rep_rdata = rep_rdata ^ 32'(1 + rand_below(255));
      if (rand_below(2) == 1) begin
        rep_addr = addr ^ (32'd1 << (2 + rand_below(30)));
        exp.addr = 1'b1;
      end
    end

    gnt0 = rand_below(3);
    rsp0 = 1 + rand_below(3);
    gnt1 = rand_below(3);
    rsp1 = 1 + rand_below(3);
    exp_q.push_back(exp);
    n_expected++;
    fork
      begin
        // The first transfer carries the byte address, the second the next word
        drive_transfer(addr, be_wide[3:0], write ? lane[31:0] : $random(seed),
                       rd0, prot, gnt0, rsp0);
        if (split) begin
          drive_transfer({addr[31:2], 2'b00} + 32'd4, be_wide[7:4],
                         write ? lane[63:32] : 32'h0, rd1, prot, gnt1, rsp1);
        end
      end
      drive_retire(ret_wait, rep_addr, write ? 4'h0 : rep_mask, write ? rep_mask : 4'h0,
                   rep_rdata, rep_wdata, rep_prot, trap, cause);
    join
  endtask

  task automatic wait_results();
    int cycles;
    cycles = 0;
    while (n_results < n_expected && cycles < 100) begin
      @(posedge clk_i);
      cycles++;
    end
    if (n_results < n_expected) begin
      err_cnt++;
      $display("Timed out at %0t waiting for a check result", $time);
    end
  endtask

  task automatic run_test(input string name, input int kind, input int count);
    int errs_before;
    errs_before = err_cnt;
    for (int i = 0; i < count; i++) begin
      run_instr(kind);
      wait_results();
    end
    compare_flag("fifo_overflow_o", fifo_overflow, 1'b0);
    compare_flag("retire_overflow_o", retire_overflow, 1'b0);
    $display("%s: %0d instructions, %0d errors", name, count, err_cnt - errs_before);
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    seed       = 32'h3723ef21;
    err_cnt    = 0;
    check_cnt  = 0;
    n_expected = 0;
    n_results  = 0;
    rst_ni         <= 1'b0;
    obi_req        <= 1'b0;
    obi_gnt        <= 1'b0;
    obi_addr       <= 32'h0;
    obi_be         <= 4'h0;
    obi_wdata      <= 32'h0;
    obi_prot       <= 3'h0;
    obi_rvalid     <= 1'b0;
    obi_rdata      <= 32'h0;
    obi_err        <= 1'b0;
    rvfi_valid     <= 1'b0;
    rvfi_addr      <= 32'h0;
    rvfi_rmask     <= 4'h0;
    rvfi_wmask     <= 4'h0;
    rvfi_rdata     <= 32'h0;
    rvfi_wdata     <= 32'h0;
    rvfi_prot      <= 3'h0;
    rvfi_trap      <= 1'b0;
    rvfi_exc_cause <= 6'h0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    compare_flag("fifo_overflow_o", fifo_overflow, 1'b0);
    compare_flag("retire_overflow_o", retire_overflow, 1'b0);
    compare_flag("check_valid_o", check_valid, 1'b0);
    $display("after_reset: %0d errors", err_cnt);

    run_test("aligned_honest", ALIGNED, 40);
    run_test("split_honest", SPLIT, 40);
    run_test("single_fault", CORRUPT, 80);
    run_test("blocked_load", BLOCKED, 30);
    run_test("no_mem_retire", NOMEM, 40);

    // Late spurious results would show up here
    repeat (20) @(posedge clk_i);
    if (n_results != n_expected) begin
      err_cnt++;
      $display("Got %0d results for %0d memory retirements", n_results, n_expected);
    end
    $display("%0d checks, %0d results, %0d errors", check_cnt, n_results, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== rvfi_mem_checker.f ====
verilog/rvfi_mem_check_pkg.sv
verilog/mem_check_ifs.sv
verilog/obi_capture_fifo.sv
verilog/retire_queue.sv
verilog/mem_op_compare.sv
verilog/rvfi_mem_checker.sv
dv/tb_rvfi_mem_checker.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the checker testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_rvfi_mem_checker -Mdir obj_dir \
  -f rvfi_mem_checker.f \
  && ./obj_dir/Vtb_rvfi_mem_checker > sim.log 2>&1 \
  || { echo "Build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "Test passed" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
